/* common/sd_pkg.sv */
// shared widths, response type codes and command word layout for the sd cmd phy and its testbench
`default_nettype none

package sd_pkg;

   // host command frame on the CMD line
   localparam int CMD_BITS = 48;

   // long response width, also the width of the response input
   localparam int RESP_BITS = 136;

   // R1, R1b, R3, R6 and R7 all use the short frame
   localparam int SHORT_RESP_BITS = 48;

   // crc7 used on every CMD line frame
   localparam int CRC7_W = 7;

   // feedback taps for x^7 + x^3 + 1, the x^7 term is implied by the shift
   localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

   // response type codes driven by the link layer
   localparam int RESP_TYPE_W = 4;

   localparam logic [RESP_TYPE_W-1:0] RESP_R1  = 4'd1;
   localparam logic [RESP_TYPE_W-1:0] RESP_R1B = 4'd2;
   localparam logic [RESP_TYPE_W-1:0] RESP_R2  = 4'd3;
   localparam logic [RESP_TYPE_W-1:0] RESP_R3  = 4'd4;
   localparam logic [RESP_TYPE_W-1:0] RESP_R6  = 4'd5;
   localparam logic [RESP_TYPE_W-1:0] RESP_R7  = 4'd6;

   // received command word
   // raw is the shift register view, f splits the same bits into the frame fields
   typedef union packed {
      logic [CMD_BITS-1:0] raw;
      struct packed {
         // always 0 on a valid frame
         logic              start_bit;
         // 1 for host to card
         logic              trans_bit;
         logic [5:0]        index;
         logic [31:0]       arg;
         logic [CRC7_W-1:0] crc;
         // always 1 on a valid frame
         logic              end_bit;
      } f;
   } cmd_word_u;

endpackage

`default_nettype wire

/* rtl/sd_crc7.sv */
// serial crc7 generator, cleared per frame and advanced one bit per clock by rx and tx
`default_nettype none
`timescale 1ns/10ps

module sd_crc7 (
   input  wire                       sd_clk,
   input  wire                       rst_i,
   input  wire                       clear_i,
   input  wire                       shift_i,
   input  wire                       bit_i,
   output logic [sd_pkg::CRC7_W-1:0] crc_o
);

   logic feedback;

   // msb out xor new bit feeds taps 0 and 3
   assign feedback = bit_i ^ crc_o[sd_pkg::CRC7_W-1];

   always_ff @(posedge sd_clk) begin
      if (rst_i) begin
         crc_o <= '0;
      end else if (clear_i) begin
         crc_o <= '0;
      end else if (shift_i) begin
         if (feedback) begin
            crc_o <= {crc_o[sd_pkg::CRC7_W-2:0], 1'b0} ^ sd_pkg::CRC7_POLY;
         end else begin
            crc_o <= {crc_o[sd_pkg::CRC7_W-2:0], 1'b0};
         end
      end
   end

endmodule

`default_nettype wire

/* cmd_rx/sd_cmd_rx.sv */
// command receiver, waits out power-up then shifts in 48-bit host commands and checks crc7
`default_nettype none
`timescale 1ns/10ps

module sd_cmd_rx #(
   parameter int WAKE_CYCLES = 60
) (
   input  wire         sd_clk,
   input  wire         rst_i,
   input  wire         cmd_i,
   input  wire         cmd_oe_i,
   input  wire         crc_disable_i,
   output logic [5:0]  cmd_index_o,
   output logic [31:0] cmd_arg_o,
   output logic        cmd_crc_ok_o,
   output logic        cmd_valid_o
);

   localparam int WAKE_W = $clog2(WAKE_CYCLES + 1);
   localparam int CNT_W  = $clog2(sd_pkg::CMD_BITS);
   // start bit, transmission bit, index and argument
   localparam int CRC_SPAN = sd_pkg::CMD_BITS - sd_pkg::CRC7_W - 1;

   localparam logic [1:0] ST_WAIT_HIGH = 2'd0;
   localparam logic [1:0] ST_WAKE      = 2'd1;
   localparam logic [1:0] ST_IDLE      = 2'd2;
   localparam logic [1:0] ST_READ      = 2'd3;

   logic [1:0]                state_q;
   logic [WAKE_W-1:0]         wake_cnt;
   logic [CNT_W-1:0]          bit_cnt;
   logic                      cmd_last;
   logic                      start_det;
   logic                      last_bit;
   logic                      crc_adv;
   logic [sd_pkg::CRC7_W-1:0] crc_calc;
   sd_pkg::cmd_word_u         cmd_q;
   sd_pkg::cmd_word_u         cmd_next;

   // falling edge on CMD while we are not driving it ourselves
   assign start_det = (state_q == ST_IDLE) && !cmd_i && cmd_last && !cmd_oe_i;
   assign last_bit  = (state_q == ST_READ) && (bit_cnt == CNT_W'(sd_pkg::CMD_BITS - 1));

   // start bit is zero and leaves a cleared crc unchanged, so bits 1..39 are enough
   assign crc_adv = (state_q == ST_READ) && (bit_cnt < CNT_W'(CRC_SPAN));

   // word as it stands once the current bit is in
   always_comb begin
      cmd_next.raw = {cmd_q.raw[sd_pkg::CMD_BITS-2:0], cmd_i};
   end

   sd_crc7 u_crc (
      .sd_clk  (sd_clk),
      .rst_i   (rst_i),
      .clear_i (start_det),
      .shift_i (crc_adv),
      .bit_i   (cmd_i),
      .crc_o   (crc_calc)
   );

   always_ff @(posedge sd_clk) begin
      if (rst_i) begin
         state_q     <= ST_WAIT_HIGH;
         wake_cnt    <= '0;
         bit_cnt     <= '0;
         cmd_last    <= 1'b0;
         cmd_valid_o <= 1'b0;
      end else begin
         cmd_last    <= cmd_i;
         cmd_valid_o <= 1'b0;
         case (state_q)
            ST_WAIT_HIGH: begin
               // host has not started clocking with CMD high yet
               if (cmd_i) begin
                  wake_cnt <= '0;
                  state_q  <= ST_WAKE;
               end
            end
            ST_WAKE: begin
               if (wake_cnt == WAKE_W'(WAKE_CYCLES - 1)) begin
                  state_q <= ST_IDLE;
               end else begin
                  wake_cnt <= wake_cnt + 1'b1;
               end
            end
            ST_IDLE: begin
               if (start_det) begin
                  bit_cnt <= CNT_W'(1);
                  state_q <= ST_READ;
               end
            end
            default: begin
               if (last_bit) begin
                  // card to host frames are not commands
                  cmd_valid_o <= cmd_next.f.trans_bit;
                  state_q     <= ST_IDLE;
               end else begin
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge sd_clk) begin
      if (start_det) begin
         cmd_q.raw <= '0;
      end else if (state_q == ST_READ) begin
         cmd_q.raw <= cmd_next.raw;
      end
      if (last_bit) begin
         cmd_index_o  <= cmd_next.f.index;
         cmd_arg_o    <= cmd_next.f.arg;
         cmd_crc_ok_o <= crc_disable_i || (cmd_next.f.crc == crc_calc);
      end
   end

endmodule

`default_nettype wire

/* resp_tx/sd_resp_tx.sv */
// response transmitter, serializes 48 or 136 bit responses on CMD with crc7 and end bit
`default_nettype none
`timescale 1ns/10ps

module sd_resp_tx (
   input  wire                            sd_clk,
   input  wire                            rst_i,
   input  wire                            resp_act_i,
   input  wire [sd_pkg::RESP_BITS-1:0]    resp_i,
   input  wire [sd_pkg::RESP_TYPE_W-1:0]  resp_type_i,
   output logic                           cmd_o,
   output logic                           cmd_oe_o,
   output logic                           resp_done_o
);

   localparam int CNT_W = $clog2(sd_pkg::RESP_BITS);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_PRE   = 2'd1;
   localparam logic [1:0] ST_WRITE = 2'd2;
   localparam logic [1:0] ST_DONE  = 2'd3;

   logic [1:0]                       state_q;
   logic [CNT_W-1:0]                 bit_cnt;
   logic [sd_pkg::RESP_BITS-1:0]     resp_q;
   logic [sd_pkg::RESP_TYPE_W-1:0]   type_q;
   logic [CNT_W-1:0]                 last_idx;
   logic [CNT_W-1:0]                 crc_lo;
   logic [CNT_W-1:0]                 crc_first;
   logic [CNT_W-1:0]                 crc_off;
   logic                             fixed_crc;
   logic                             latch;
   logic                             crc_adv;
   logic                             tx_bit;
   logic [sd_pkg::CRC7_W-1:0]        crc_calc;

   assign latch = (state_q == ST_IDLE) && resp_act_i;

   // frame length and crc span per response type
   always_comb begin
      last_idx  = CNT_W'(sd_pkg::SHORT_RESP_BITS - 1);
      crc_lo    = '0;
      fixed_crc = 1'b0;
      case (type_q)
         sd_pkg::RESP_R2: begin
            // long response skips the 8 header bits
            last_idx = CNT_W'(sd_pkg::RESP_BITS - 1);
            crc_lo   = CNT_W'(8);
         end
         sd_pkg::RESP_R3: begin
            fixed_crc = 1'b1;
         end
         sd_pkg::RESP_R1, sd_pkg::RESP_R1B, sd_pkg::RESP_R6, sd_pkg::RESP_R7: begin
            fixed_crc = 1'b0;
         end
         default: begin
            fixed_crc = 1'b0;
         end
      endcase
   end

   assign crc_first = last_idx - CNT_W'(sd_pkg::CRC7_W);
   assign crc_adv   = (state_q == ST_WRITE) && (bit_cnt >= crc_lo) && (bit_cnt < crc_first);

   // position inside the crc field, msb first
   assign crc_off = last_idx - CNT_W'(1) - bit_cnt;

   always_comb begin
      if (bit_cnt == last_idx) begin
         tx_bit = 1'b1;
      end else if (bit_cnt >= crc_first) begin
         tx_bit = fixed_crc ? 1'b1 : crc_calc[crc_off[2:0]];
      end else begin
         tx_bit = resp_q[sd_pkg::RESP_BITS-1];
      end
   end

   sd_crc7 u_crc (
      .sd_clk  (sd_clk),
      .rst_i   (rst_i),
      .clear_i (latch),
      .shift_i (crc_adv),
      .bit_i   (resp_q[sd_pkg::RESP_BITS-1]),
      .crc_o   (crc_calc)
   );

   always_ff @(posedge sd_clk) begin
      if (rst_i) begin
         state_q     <= ST_IDLE;
         bit_cnt     <= '0;
         cmd_o       <= 1'b1;
         cmd_oe_o    <= 1'b0;
         resp_done_o <= 1'b0;
      end else begin
         resp_done_o <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (resp_act_i) begin
                  state_q <= ST_PRE;
               end
            end
            ST_PRE: begin
               bit_cnt <= '0;
               state_q <= ST_WRITE;
            end
            ST_WRITE: begin
               cmd_oe_o <= 1'b1;
               cmd_o    <= tx_bit;
               if (bit_cnt == last_idx) begin
                  state_q <= ST_DONE;
               end else begin
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            default: begin
               // release the line, the host drives the pull-up level again
               cmd_oe_o    <= 1'b0;
               cmd_o       <= 1'b1;
               resp_done_o <= 1'b1;
               state_q     <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge sd_clk) begin
      if (latch) begin
         resp_q <= resp_i;
         type_q <= resp_type_i;
      end else if (state_q == ST_WRITE) begin
         resp_q <= {resp_q[sd_pkg::RESP_BITS-2:0], 1'b1};
      end
   end

endmodule

`default_nettype wire

/* rtl/sd_cmd_phy.sv */
// top of the sd CMD line phy, joins command receiver and response transmitter on one pin
`default_nettype none
`timescale 1ns/10ps

module sd_cmd_phy #(
   parameter int WAKE_CYCLES = 60
) (
   input  wire                            sd_clk,
   input  wire                            rst_i,

   // CMD pin
   input  wire                            cmd_i,
   output logic                           cmd_o,
   output logic                           cmd_oe_o,

   // received commands
   input  wire                            crc_disable_i,
   output logic [5:0]                     cmd_index_o,
   output logic [31:0]                    cmd_arg_o,
   output logic                           cmd_crc_ok_o,
   output logic                           cmd_valid_o,

   // responses from the link layer
   input  wire                            resp_act_i,
   input  wire [sd_pkg::RESP_BITS-1:0]    resp_i,
   input  wire [sd_pkg::RESP_TYPE_W-1:0]  resp_type_i,
   output logic                           resp_done_o
);

   // high while the transmitter owns the CMD line
   logic cmd_oe;

   assign cmd_oe_o = cmd_oe;

   sd_cmd_rx #(
      .WAKE_CYCLES (WAKE_CYCLES)
   ) u_cmd_rx (
      .sd_clk        (sd_clk),
      .rst_i         (rst_i),
      .cmd_i         (cmd_i),
      .cmd_oe_i      (cmd_oe),
      .crc_disable_i (crc_disable_i),
      .cmd_index_o   (cmd_index_o),
      .cmd_arg_o     (cmd_arg_o),
      .cmd_crc_ok_o  (cmd_crc_ok_o),
      .cmd_valid_o   (cmd_valid_o)
   );

   sd_resp_tx u_resp_tx (
      .sd_clk      (sd_clk),
      .rst_i       (rst_i),
      .resp_act_i  (resp_act_i),
      .resp_i      (resp_i),
      .resp_type_i (resp_type_i),
      .cmd_o       (cmd_o),
      .cmd_oe_o    (cmd_oe),
      .resp_done_o (resp_done_o)
   );

endmodule

`default_nettype wire

/* tb/sd_host_model.svh */
// host side reference model for the cmd phy testbench, included into the testbench module
`ifndef SD_HOST_MODEL_SVH
`define SD_HOST_MODEL_SVH

// crc7 over the low len bits of data, msb first, x^7 + x^3 + 1
function automatic logic [6:0] crc7_ref(input logic [135:0] data, input int len);
   logic [6:0] c;
   logic       fb;
   c = '0;
   for (int i = len - 1; i >= 0; i--) begin
      fb   = data[i] ^ c[6];
      c    = {c[5:0], fb};
      c[3] = c[3] ^ fb;
   end
   return c;
endfunction

// framed host command with its crc over start bit to argument
function automatic logic [47:0] build_cmd(input logic [5:0]  index,
                                          input logic [31:0] arg,
                                          input logic        trans);
   sd_pkg::cmd_word_u w;
   w.raw         = '0;
   w.f.start_bit = 1'b0;
   w.f.trans_bit = trans;
   w.f.index     = index;
   w.f.arg       = arg;
   w.f.crc       = crc7_ref(w.raw[47:8], 40);
   w.f.end_bit   = 1'b1;
   return w.raw;
endfunction

// number of bits the card drives for a response type
function automatic int resp_len(input logic [3:0] rtype);
   if (rtype == sd_pkg::RESP_R2) begin
      return sd_pkg::RESP_BITS;
   end else begin
      return sd_pkg::SHORT_RESP_BITS;
   end
endfunction

// expected CMD line bits, first bit sent at index resp_len - 1
function automatic logic [135:0] resp_stream(input logic [135:0] resp,
                                             input logic [3:0]   rtype);
   logic [6:0]   crc;
   logic [135:0] s;
   if (rtype == sd_pkg::RESP_R2) begin
      // the leading 8 bits go out but stay outside the crc
      crc = crc7_ref(resp[127:8], 120);
      s   = {resp[135:8], crc, 1'b1};
   end else begin
      if (rtype == sd_pkg::RESP_R3) begin
         crc = 7'h7f;
      end else begin
         crc = crc7_ref(resp[135:96], 40);
      end
      s = {88'h0, resp[135:96], crc, 1'b1};
   end
   return s;
endfunction

`endif

/* tb/tb_sd_cmd_phy.sv */
// testbench for the sd cmd phy, sends host commands and responses and checks them against a model
`default_nettype none
`timescale 1ns/10ps

module tb_sd_cmd_phy;

   localparam int WAKE_CYCLES  = 60;
   localparam int CLK_HALF     = 50;
   localparam int DRIVE_DLY    = 10;
   localparam int RESET_CYCLES = 16;
   // longest response plus preamble, with margin
   localparam int WAIT_LIMIT   = 400;

   logic                           sd_clk;
   logic                           rst_i;
   logic                           cmd_i;
   logic                           crc_disable_i;
   logic                           resp_act_i;
   logic [sd_pkg::RESP_BITS-1:0]   resp_i;
   logic [sd_pkg::RESP_TYPE_W-1:0] resp_type_i;
   wire                            cmd_o;
   wire                            cmd_oe_o;
   wire  [5:0]                     cmd_index_o;
   wire  [31:0]                    cmd_arg_o;
   wire                            cmd_crc_ok_o;
   wire                            cmd_valid_o;
   wire                            resp_done_o;

   // filled by the sampler on falling edges
   logic        tx_bits[$];
   logic [5:0]  rx_index_q[$];
   logic [31:0] rx_arg_q[$];
   logic        rx_ok_q[$];
   int          done_cnt = 0;
   logic        oe_at_done = 1'b0;

   int          done_ref;
   integer      seed;

   `include "sd_host_model.svh"

   sd_cmd_phy #(
      .WAKE_CYCLES (WAKE_CYCLES)
   ) UUT (
      .sd_clk        (sd_clk),
      .rst_i         (rst_i),
      .cmd_i         (cmd_i),
      .cmd_o         (cmd_o),
      .cmd_oe_o      (cmd_oe_o),
      .crc_disable_i (crc_disable_i),
      .cmd_index_o   (cmd_index_o),
      .cmd_arg_o     (cmd_arg_o),
      .cmd_crc_ok_o  (cmd_crc_ok_o),
      .cmd_valid_o   (cmd_valid_o),
      .resp_act_i    (resp_act_i),
      .resp_i        (resp_i),
      .resp_type_i   (resp_type_i),
      .resp_done_o   (resp_done_o)
   );

   initial begin
      sd_clk = 1'b0;
      forever #CLK_HALF sd_clk = ~sd_clk;
   end

   // mid-cycle sampler for the pin and the decoded outputs
   always @(negedge sd_clk) begin
      if (cmd_oe_o) begin
         tx_bits.push_back(cmd_o);
      end
      if (cmd_valid_o) begin
         rx_index_q.push_back(cmd_index_o);
         rx_arg_q.push_back(cmd_arg_o);
         rx_ok_q.push_back(cmd_crc_ok_o);
      end
      if (resp_done_o) begin
         done_cnt   = done_cnt + 1;
         oe_at_done = cmd_oe_o;
      end
   end

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic drive_bit(input logic b);
      @(posedge sd_clk);
      #DRIVE_DLY;
      cmd_i = b;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_bit(1'b1);
   endtask

   task automatic send_frame(input logic [47:0] frame);
      for (int i = 47; i >= 0; i--) begin
         drive_bit(frame[i]);
      end
      drive_bit(1'b1);
   endtask

   task automatic random_payload(output logic [135:0] r);
      logic [31:0] word;
      r = '0;
      repeat (5) begin
         word = $random(seed);
         r    = {r[103:0], word};
      end
   endtask

   task automatic check_command(input logic [5:0] index, input logic [31:0] arg,
                                input logic crc_ok);
      int          n;
      logic [5:0]  got_index;
      logic [31:0] got_arg;
      logic        got_ok;
      n = 0;
      while (rx_index_q.size() == 0 && n < WAIT_LIMIT) begin
         @(posedge sd_clk);
         n++;
      end
      assert (rx_index_q.size() != 0) else fail_stop("timed out waiting for cmd_valid_o");
      got_index = rx_index_q.pop_front();
      got_arg   = rx_arg_q.pop_front();
      got_ok    = rx_ok_q.pop_front();
      assert (got_index == index) else
         fail_stop($sformatf("[FAIL] cmd_index_o = 0x%h, expected 0x%h", got_index, index));
      assert (got_arg == arg) else
         fail_stop($sformatf("[FAIL] cmd_arg_o = 0x%h, expected 0x%h", got_arg, arg));
      assert (got_ok == crc_ok) else
         fail_stop($sformatf("[FAIL] cmd_crc_ok_o = 0x%h, expected 0x%h", got_ok, crc_ok));
   endtask

   task automatic pulse_resp(input logic [135:0] payload, input logic [3:0] rtype);
      @(posedge sd_clk);
      #DRIVE_DLY;
      resp_i      = payload;
      resp_type_i = rtype;
      resp_act_i  = 1'b1;
      @(posedge sd_clk);
      #DRIVE_DLY;
      resp_act_i  = 1'b0;
      resp_i      = '0;
   endtask

   task automatic start_response(input logic [135:0] payload, input logic [3:0] rtype);
      tx_bits.delete();
      done_ref = done_cnt;
      pulse_resp(payload, rtype);
   endtask

   task automatic wait_oe_high();
      int n;
      n = 0;
      while (tx_bits.size() == 0 && n < WAIT_LIMIT) begin
         @(posedge sd_clk);
         n++;
      end
      assert (tx_bits.size() != 0) else fail_stop("timed out waiting for cmd_oe_o to rise");
   endtask

   task automatic check_response(input logic [135:0] payload, input logic [3:0] rtype);
      int           n;
      int           len;
      logic [135:0] stream;
      len    = resp_len(rtype);
      stream = resp_stream(payload, rtype);
      n      = 0;
      while (done_cnt == done_ref && n < WAIT_LIMIT) begin
         @(posedge sd_clk);
         n++;
      end
      assert (done_cnt != done_ref) else fail_stop("timed out waiting for resp_done_o");
      assert (oe_at_done == 1'b0) else
         fail_stop($sformatf("[FAIL] cmd_oe_o = 0x%h with resp_done_o, expected 0x0", oe_at_done));
      assert (tx_bits.size() == len) else
         fail_stop($sformatf("[FAIL] cmd_oe_o high for 0x%h clocks, expected 0x%h",
                             tx_bits.size(), len));
      for (int i = 0; i < len; i++) begin
         assert (tx_bits[i] == stream[len-1-i]) else
            fail_stop($sformatf("[FAIL] cmd_o bit 0x%h = 0x%h, expected 0x%h",
                                i, tx_bits[i], stream[len-1-i]));
      end
   endtask

   initial begin
      logic [5:0]   index;
      logic [31:0]  arg;
      logic [47:0]  frame;
      logic [135:0] payload;
      logic [135:0] other;
      int           pos;
      logic [3:0]   short_types [4];
      seed          = 57;
      short_types   = '{sd_pkg::RESP_R1, sd_pkg::RESP_R1B, sd_pkg::RESP_R6, sd_pkg::RESP_R7};
      rst_i         = 1'b1;
      cmd_i         = 1'b0;
      crc_disable_i = 1'b0;
      resp_act_i    = 1'b0;
      resp_i        = '0;
      resp_type_i   = sd_pkg::RESP_R1;
      repeat (RESET_CYCLES) @(posedge sd_clk);
      #DRIVE_DLY;
      rst_i = 1'b0;

      assert (cmd_oe_o === 1'b0) else
         fail_stop($sformatf("[FAIL] cmd_oe_o = 0x%h after reset, expected 0x0", cmd_oe_o));
      assert (cmd_valid_o === 1'b0) else
         fail_stop($sformatf("[FAIL] cmd_valid_o = 0x%h after reset, expected 0x0", cmd_valid_o));
      assert (resp_done_o === 1'b0) else
         fail_stop($sformatf("[FAIL] resp_done_o = 0x%h after reset, expected 0x0", resp_done_o));

      // command inside the wake-up window must be dropped
      idle_cycles(3);
      index = $random(seed);
      arg   = $random(seed);
      send_frame(build_cmd(index, arg, 1'b1));
      idle_cycles(WAKE_CYCLES + 8);
      assert (rx_index_q.size() == 0) else fail_stop("command decoded before wake-up ended");

      repeat (8) begin
         index = $random(seed);
         arg   = $random(seed);
         send_frame(build_cmd(index, arg, 1'b1));
         check_command(index, arg, 1'b1);
         idle_cycles(4);
      end

      // one flipped bit inside the crc field
      index = $random(seed);
      arg   = $random(seed);
      pos   = 1 + ($unsigned($random(seed)) % 7);
      frame = build_cmd(index, arg, 1'b1);
      frame[pos] = ~frame[pos];
      send_frame(frame);
      check_command(index, arg, 1'b0);
      idle_cycles(2);
      crc_disable_i = 1'b1;
      send_frame(frame);
      check_command(index, arg, 1'b1);
      idle_cycles(2);
      crc_disable_i = 1'b0;

      foreach (short_types[t]) begin
         random_payload(payload);
         start_response(payload, short_types[t]);
         check_response(payload, short_types[t]);
         idle_cycles(3);
      end

      // long response, a second request while busy is ignored
      random_payload(payload);
      random_payload(other);
      start_response(payload, sd_pkg::RESP_R2);
      wait_oe_high();
      pulse_resp(other, sd_pkg::RESP_R1);
      check_response(payload, sd_pkg::RESP_R2);
      idle_cycles(20);
      assert (tx_bits.size() == sd_pkg::RESP_BITS && done_cnt == done_ref + 1) else
         fail_stop("resp_act_i during a response started a second response");

      random_payload(payload);
      start_response(payload, sd_pkg::RESP_R3);
      check_response(payload, sd_pkg::RESP_R3);
      idle_cycles(3);

      // command overlapping our own response
      random_payload(payload);
      start_response(payload, sd_pkg::RESP_R2);
      wait_oe_high();
      index = $random(seed);
      arg   = $random(seed);
      send_frame(build_cmd(index, arg, 1'b1));
      check_response(payload, sd_pkg::RESP_R2);
      idle_cycles(WAKE_CYCLES);
      assert (rx_index_q.size() == 0) else fail_stop("command decoded while cmd_oe_o was high");
      send_frame(build_cmd(index, arg, 1'b1));
      check_command(index, arg, 1'b1);
      idle_cycles(4);

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+tb
common/sd_pkg.sv
rtl/sd_crc7.sv
cmd_rx/sd_cmd_rx.sv
resp_tx/sd_resp_tx.sv
rtl/sd_cmd_phy.sv
tb/tb_sd_cmd_phy.sv
